// File: include/alu_cfg.svh
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Q6.10 fixed-point format
`define ALU_INT_W  6
`define ALU_FRAC_W 10
`define ALU_DATA_W (`ALU_INT_W + `ALU_FRAC_W)

// full signed product
`define ALU_PROD_W (2 * `ALU_DATA_W)

`define ALU_OP_W 4

// iteration count and target, wide enough for 32
`define ALU_ITER_W 6

// LFSR step count comes from b[4:0]
`define ALU_STEP_W 5

// leading-zero count, 0 to 16
`define ALU_CLZ_W 5

// feedback taps at bits 15, 13, 12 and 10
`define ALU_LFSR_TAPS 16'hB400

`endif

// File: rtl/alu_pkg.sv
`include "alu_cfg.svh"

package alu_pkg;

    typedef logic [`ALU_DATA_W-1:0] data_t;
    typedef logic [`ALU_PROD_W-1:0] prod_t;
    typedef logic [`ALU_ITER_W-1:0] iter_t;

    // values 4, 8 and 9 are no-ops
    typedef enum logic [`ALU_OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MUL  = 4'd2,
        OP_MAC  = 4'd3,
        OP_CLZ  = 4'd5,
        OP_LRCW = 4'd6,
        OP_LFSR = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_EXEC = 2'd1,
        S_ITER = 2'd2,
        S_DONE = 2'd3
    } alu_state_e;

    typedef struct packed {
        alu_op_e op;
        data_t   a;
        data_t   b;
    } alu_cmd_t;

endpackage

// File: rtl/alu_ctrl_fsm.sv
module alu_ctrl_fsm (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  alu_pkg::alu_cmd_t i_cmd,
    input  logic              i_iter_done,
    output alu_pkg::alu_cmd_t o_cmd,
    output logic              o_exec_start,
    output logic              o_iter_en,
    output logic              o_result_load,
    output logic              o_busy,
    output logic              o_valid
);
    import alu_pkg::*;

    alu_state_e state_q;
    alu_state_e state_d;
    alu_cmd_t   cmd_q;
    logic       acc_q;
    logic       accept;
    logic       is_iter;
    logic       finish;

    assign accept  = i_valid && !o_busy;
    assign is_iter = (cmd_q.op == OP_LRCW) || (cmd_q.op == OP_LFSR);
    // non-iterative ops and zero targets go straight to S_DONE
    assign finish  = i_iter_done || !is_iter;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (acc_q) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                state_d = finish ? S_DONE : S_ITER;
            end
            S_ITER: begin
                if (finish) begin
                    state_d = S_DONE;
                end
            end
            S_DONE: begin
                state_d = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            acc_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            acc_q   <= accept;
        end
    end

    // held command, read by all data blocks
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd_q <= i_cmd;
        end
    end

    assign o_cmd         = cmd_q;
    assign o_exec_start  = (state_q == S_EXEC);
    assign o_iter_en     = (state_q == S_ITER);
    assign o_result_load = ((state_q == S_EXEC) || (state_q == S_ITER)) && finish;
    assign o_busy        = acc_q || (state_q != S_IDLE);
    assign o_valid       = (state_q == S_DONE);

    // valid is a one-cycle pulse inside the busy window
    a_valid_in_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid |-> o_busy ##1 !o_valid);

    // no new command replaces the held one while busy
    a_cmd_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_busy |=> $stable(cmd_q));

endmodule

// File: rtl/alu_iter_count.sv
`include "alu_cfg.svh"

module alu_iter_count (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  alu_pkg::alu_cmd_t i_cmd,
    input  alu_pkg::iter_t    i_popcount,
    input  logic              i_start,
    input  logic              i_step,
    output logic              o_done
);
    import alu_pkg::*;

    iter_t target;
    iter_t count_q;
    iter_t count_d;

    always_comb begin
        case (i_cmd.op)
            OP_LRCW: target = i_popcount;
            OP_LFSR: target = iter_t'(i_cmd.b[`ALU_STEP_W-1:0]);
            default: target = '0;
        endcase
    end

    always_comb begin
        count_d = count_q;
        if (i_start) begin
            count_d = '0;
        end else if (i_step) begin
            count_d = count_q + iter_t'(1);
        end
    end

    // done looks at the count after this edge, so a zero target finishes in exec
    assign o_done = (count_d == target);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else begin
            count_q <= count_d;
        end
    end

    a_count_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_step |-> count_q < target);

endmodule

// File: rtl/alu_bit_count.sv
`include "alu_cfg.svh"

module alu_bit_count (
    input  alu_pkg::data_t i_a,
    output alu_pkg::data_t o_clz,
    output alu_pkg::iter_t o_popcount
);
    import alu_pkg::*;

    logic [`ALU_CLZ_W-1:0] clz;
    logic [7:0]            val8;
    logic [3:0]            val4;
    logic [1:0]            val2;
    iter_t                 pop;

    // binary search, halving the window each level
    always_comb begin
        clz  = '0;
        val8 = '0;
        val4 = '0;
        val2 = '0;
        if (i_a == '0) begin
            clz = {1'b1, {(`ALU_CLZ_W-1){1'b0}}};
        end else begin
            clz[3] = (i_a[15:8] == 8'd0);
            val8   = clz[3] ? i_a[7:0] : i_a[15:8];
            clz[2] = (val8[7:4] == 4'd0);
            val4   = clz[2] ? val8[3:0] : val8[7:4];
            clz[1] = (val4[3:2] == 2'd0);
            val2   = clz[1] ? val4[1:0] : val4[3:2];
            clz[0] = !val2[1];
        end
    end

    always_comb begin
        pop = '0;
        for (int i = 0; i < `ALU_DATA_W; i++) begin
            pop = pop + iter_t'(i_a[i]);
        end
    end

    assign o_clz      = data_t'(clz);
    assign o_popcount = pop;

endmodule

// File: rtl/alu_iter_shift.sv
`include "alu_cfg.svh"

module alu_iter_shift (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  alu_pkg::alu_cmd_t i_cmd,
    input  logic              i_load,
    input  logic              i_step,
    output alu_pkg::data_t    o_lrcw,
    output alu_pkg::data_t    o_lfsr
);
    import alu_pkg::*;

    data_t lrcw_q;
    data_t lrcw_d;
    data_t lfsr_q;
    data_t lfsr_d;

    always_comb begin
        lrcw_d = lrcw_q;
        lfsr_d = lfsr_q;
        if (i_load) begin
            lrcw_d = i_cmd.b;
            lfsr_d = i_cmd.a;
        end else if (i_step) begin
            // rotate left, inverting the bit that wraps
            lrcw_d = {lrcw_q[`ALU_DATA_W-2:0], ~lrcw_q[`ALU_DATA_W-1]};
            lfsr_d = {lfsr_q[`ALU_DATA_W-2:0], ^(lfsr_q & `ALU_LFSR_TAPS)};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lrcw_q <= '0;
            lfsr_q <= '0;
        end else begin
            lrcw_q <= lrcw_d;
            lfsr_q <= lfsr_d;
        end
    end

    // next-state values, so the result register catches the final step
    // on the same edge
    assign o_lrcw = lrcw_d;
    assign o_lfsr = lfsr_d;

endmodule

// File: rtl/alu_arith_acc.sv
`include "alu_cfg.svh"

module alu_arith_acc (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  alu_pkg::alu_cmd_t i_cmd,
    input  logic              i_load,
    input  alu_pkg::data_t    i_clz,
    input  alu_pkg::data_t    i_lrcw,
    input  alu_pkg::data_t    i_lfsr,
    output alu_pkg::data_t    o_data
);
    import alu_pkg::*;

    localparam data_t SAT_MAX = {1'b0, {(`ALU_DATA_W-1){1'b1}}};
    localparam data_t SAT_MIN = {1'b1, {(`ALU_DATA_W-1){1'b0}}};

    data_t                       sum;
    data_t                       diff;
    data_t                       add_res;
    data_t                       sub_res;
    data_t                       mul_res;
    data_t                       mac_res;
    data_t                       res_d;
    prod_t                       prod;
    logic signed [`ALU_PROD_W:0] mac_wide;

    // drop the fraction, round half up on bit 9, clamp to Q6.10
    function automatic data_t round_sat(input logic signed [`ALU_PROD_W:0] v);
        logic signed [`ALU_PROD_W:0]          t;
        logic [`ALU_PROD_W-`ALU_DATA_W+1:0]   hi;
        t  = v >>> `ALU_FRAC_W;
        t  = t + {{`ALU_PROD_W{1'b0}}, v[`ALU_FRAC_W-1]};
        hi = t[`ALU_PROD_W:`ALU_DATA_W-1];
        if (hi == '0 || hi == '1) begin
            return t[`ALU_DATA_W-1:0];
        end
        return t[`ALU_PROD_W] ? SAT_MIN : SAT_MAX;
    endfunction

    assign sum  = i_cmd.a + i_cmd.b;
    assign diff = i_cmd.a - i_cmd.b;

    // overflow when the result sign disagrees with like-signed inputs
    always_comb begin
        add_res = sum;
        if ((i_cmd.a[`ALU_DATA_W-1] == i_cmd.b[`ALU_DATA_W-1]) &&
            (sum[`ALU_DATA_W-1] != i_cmd.a[`ALU_DATA_W-1])) begin
            add_res = i_cmd.a[`ALU_DATA_W-1] ? SAT_MIN : SAT_MAX;
        end
        sub_res = diff;
        if ((i_cmd.a[`ALU_DATA_W-1] != i_cmd.b[`ALU_DATA_W-1]) &&
            (diff[`ALU_DATA_W-1] != i_cmd.a[`ALU_DATA_W-1])) begin
            sub_res = i_cmd.a[`ALU_DATA_W-1] ? SAT_MIN : SAT_MAX;
        end
    end

    assign prod = $signed(i_cmd.a) * $signed(i_cmd.b);

    // accumulator moved up to the product scale, 20 fraction bits
    assign mac_wide = $signed({prod[`ALU_PROD_W-1], prod}) +
                      $signed({{(`ALU_INT_W+1){o_data[`ALU_DATA_W-1]}}, o_data,
                               {`ALU_FRAC_W{1'b0}}});

    assign mul_res = round_sat($signed({prod[`ALU_PROD_W-1], prod}));
    assign mac_res = round_sat(mac_wide);

    always_comb begin
        case (i_cmd.op)
            OP_ADD:  res_d = add_res;
            OP_SUB:  res_d = sub_res;
            OP_MUL:  res_d = mul_res;
            OP_MAC:  res_d = mac_res;
            OP_CLZ:  res_d = i_clz;
            OP_LRCW: res_d = i_lrcw;
            OP_LFSR: res_d = i_lfsr;
            // no-op keeps the last result
            default: res_d = o_data;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data <= '0;
        end else if (i_load) begin
            o_data <= res_d;
        end
    end

endmodule

// File: rtl/alu_top.sv
module alu_top (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  alu_pkg::alu_cmd_t i_cmd,
    output logic              o_valid,
    output logic              o_busy,
    output alu_pkg::data_t    o_data
);
    import alu_pkg::*;

    alu_cmd_t cmd_q;
    logic     exec_start;
    logic     iter_en;
    logic     result_load;
    logic     iter_done;
    data_t    clz;
    iter_t    popcount;
    data_t    lrcw;
    data_t    lfsr;

    alu_ctrl_fsm alu_ctrl_fsm_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (i_valid),
        .i_cmd         (i_cmd),
        .i_iter_done   (iter_done),
        .o_cmd         (cmd_q),
        .o_exec_start  (exec_start),
        .o_iter_en     (iter_en),
        .o_result_load (result_load),
        .o_busy        (o_busy),
        .o_valid       (o_valid)
    );

    alu_iter_count alu_iter_count_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (cmd_q),
        .i_popcount (popcount),
        .i_start    (exec_start),
        .i_step     (iter_en),
        .o_done     (iter_done)
    );

    alu_bit_count alu_bit_count_i (
        .i_a        (cmd_q.a),
        .o_clz      (clz),
        .o_popcount (popcount)
    );

    alu_iter_shift alu_iter_shift_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (cmd_q),
        .i_load  (exec_start),
        .i_step  (iter_en),
        .o_lrcw  (lrcw),
        .o_lfsr  (lfsr)
    );

    alu_arith_acc alu_arith_acc_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_cmd   (cmd_q),
        .i_load  (result_load),
        .i_clz   (clz),
        .i_lrcw  (lrcw),
        .i_lfsr  (lfsr),
        .o_data  (o_data)
    );

endmodule

// File: dv/alu_checker.sv
module alu_checker (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_valid,
    input  logic            i_busy,
    input  alu_pkg::data_t  i_data,
    input  logic [8*12-1:0] i_name,
    input  alu_pkg::data_t  i_expected,
    output int              o_errors,
    output int              o_checks
);
    import alu_pkg::*;

    // longest command is 34 busy cycles
    localparam int BUSY_LIMIT = 40;

    int   errors   = 0;
    int   checks   = 0;
    int   busy_run = 0;
    logic rst_prev = 1'b0;

    always @(negedge i_clk) begin
        // outputs still at reset values right after release
        if (i_rst_n && !rst_prev) begin
            if (i_valid || i_busy || (i_data != '0)) begin
                $display("outputs not at reset values after reset: valid %b busy %b data %h",
                         i_valid, i_busy, i_data);
                errors++;
            end
        end
        rst_prev = i_rst_n;
        if (i_rst_n) begin
            if (i_valid) begin
                checks++;
                if (!i_busy) begin
                    $display("valid pulse seen while busy was low (%0s)", i_name);
                    errors++;
                end
                if (i_data !== i_expected) begin
                    $display("Fail %0s: expected %h, actual %h", i_name, i_expected, i_data);
                    errors++;
                end
            end
            busy_run = i_busy ? busy_run + 1 : 0;
            if (busy_run == BUSY_LIMIT) begin
                $display("busy stuck high for %0d cycles (%0s)", BUSY_LIMIT, i_name);
                errors++;
            end
        end
    end

    assign o_errors = errors;
    assign o_checks = checks;

endmodule

// File: dv/alu_tb.sv
module alu_tb;
    import alu_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int CYC_PER_VEC  = 40;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic [3:0]      op;
        data_t           a;
        data_t           b;
        data_t           expected;
    } vec_t;

    logic            clk;
    logic            rst_n;
    logic            valid;
    alu_cmd_t        cmd;
    logic            dut_valid;
    logic            dut_busy;
    data_t           dut_data;
    logic [8*12-1:0] exp_name;
    data_t           exp_data;
    int              errors;
    int              checks;
    vec_t            vecs[$];

    alu_top alu_top_i (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_valid (valid),
        .i_cmd   (cmd),
        .o_valid (dut_valid),
        .o_busy  (dut_busy),
        .o_data  (dut_data)
    );

    alu_checker alu_checker_i (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_valid    (dut_valid),
        .i_busy     (dut_busy),
        .i_data     (dut_data),
        .i_name     (exp_name),
        .i_expected (exp_data),
        .o_errors   (errors),
        .o_checks   (checks)
    );

    function automatic int popcount(input data_t v);
        int n;
        n = 0;
        for (int i = 0; i < $bits(data_t); i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    // rotate left with the wrapped bit inverted
    function automatic data_t lrcw_model(input data_t b, input int steps);
        data_t v;
        v = b;
        for (int i = 0; i < steps; i++) begin
            v = {v[14:0], ~v[15]};
        end
        return v;
    endfunction

    // shift left, feedback from taps 15, 13, 12, 10
    function automatic data_t lfsr_model(input data_t a, input int steps);
        data_t v;
        v = a;
        for (int i = 0; i < steps; i++) begin
            v = {v[14:0], v[15] ^ v[13] ^ v[12] ^ v[10]};
        end
        return v;
    endfunction

    function automatic data_t expected_for(input vec_t v, input data_t prev);
        data_t r;
        case (v.op)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd5: r = v.expected;
            4'd6:    r = lrcw_model(v.b, popcount(v.a));
            4'd7:    r = lfsr_model(v.a, int'(v.b[4:0]));
            default: r = prev;
        endcase
        return r;
    endfunction

    function automatic void add_vec(input logic [8*12-1:0] name, input logic [3:0] op,
                                    input data_t a, input data_t b, input data_t expected);
        vec_t v;
        v.name     = name;
        v.op       = op;
        v.a        = a;
        v.b        = b;
        v.expected = expected;
        vecs.push_back(v);
    endfunction

    // shift and no-op rows take their value from the models
    function automatic void load_table();
        add_vec("nop_first", 4'd8, 16'h1234, 16'h5678, 16'h0000);
        add_vec("add_in",    4'd0, 16'h0400, 16'h0200, 16'h0600);
        add_vec("add_satp",  4'd0, 16'h7000, 16'h2000, 16'h7FFF);
        add_vec("add_satn",  4'd0, 16'h8000, 16'hFC00, 16'h8000);
        add_vec("sub_in",    4'd1, 16'h0400, 16'h0C00, 16'hF800);
        add_vec("sub_satp",  4'd1, 16'h7C00, 16'h8000, 16'h7FFF);
        add_vec("sub_satn",  4'd1, 16'h8400, 16'h0800, 16'h8000);
        add_vec("mul_exact", 4'd2, 16'h0800, 16'h0600, 16'h0C00);
        add_vec("mul_round", 4'd2, 16'h0401, 16'h0200, 16'h0201);
        add_vec("mul_satp",  4'd2, 16'h4000, 16'h4000, 16'h7FFF);
        add_vec("mul_satn",  4'd2, 16'h4000, 16'hC000, 16'h8000);
        add_vec("mul_neg",   4'd2, 16'hFC00, 16'h0600, 16'hFA00);
        // chain on -1.5 from the row above
        add_vec("mac_1",     4'd3, 16'h0800, 16'h0400, 16'h0200);
        add_vec("mac_2",     4'd3, 16'h0C00, 16'h0C00, 16'h2600);
        add_vec("mac_sat",   4'd3, 16'h4000, 16'h0C00, 16'h7FFF);
        add_vec("mac_desat", 4'd3, 16'hFC00, 16'h4000, 16'h3FFF);
        add_vec("mac_round", 4'd3, 16'h0001, 16'h0200, 16'h4000);
        add_vec("clz_zero",  4'd5, 16'h0000, 16'h0000, 16'h0010);
        add_vec("clz_msb",   4'd5, 16'h8000, 16'h0000, 16'h0000);
        add_vec("clz_mid",   4'd5, 16'h00F0, 16'h0000, 16'h0008);
        add_vec("clz_mid2",  4'd5, 16'h0123, 16'hFFFF, 16'h0007);
        add_vec("lrcw_t0",   4'd6, 16'h0000, 16'h1234, 16'h0000);
        add_vec("lrcw_t1",   4'd6, 16'h0010, 16'h8001, 16'h0000);
        add_vec("lrcw_many", 4'd6, 16'h0F0F, 16'hA5C3, 16'h0000);
        add_vec("lrcw_full", 4'd6, 16'hFFFF, 16'h00FF, 16'h0000);
        add_vec("lfsr_t0",   4'd7, 16'hACE1, 16'h0000, 16'h0000);
        add_vec("lfsr_t1",   4'd7, 16'hACE1, 16'h0001, 16'h0000);
        add_vec("lfsr_many", 4'd7, 16'hACE1, 16'h001F, 16'h0000);
        add_vec("lfsr_hi_b", 4'd7, 16'h1F35, 16'hFFE7, 16'h0000);
        add_vec("nop_4",     4'd4, 16'h1111, 16'h2222, 16'h0000);
        add_vec("nop_9",     4'd9, 16'h3333, 16'h4444, 16'h0000);
    endfunction

    task automatic run_vector(input vec_t v, inout data_t prev);
        @(negedge clk);
        while (dut_busy) begin
            @(negedge clk);
        end
        exp_name = v.name;
        exp_data = expected_for(v, prev);
        cmd      = {v.op, v.a, v.b};
        valid    = 1'b1;
        @(negedge clk);
        valid = 1'b0;
        while (!dut_valid) begin
            @(negedge clk);
        end
        prev = exp_data;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        @(posedge rst_n);
        #(CLK_PERIOD * CYC_PER_VEC * vecs.size());
        $display("timeout: the DUT did not finish the command table in time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        data_t prev;
        rst_n    = 1'b0;
        valid    = 1'b0;
        cmd      = '0;
        exp_name = '0;
        exp_data = '0;
        prev     = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (vecs[i]) begin
            run_vector(vecs[i], prev);
        end
        repeat (2) @(negedge clk);
        if (checks != vecs.size()) begin
            $display("number of valid pulses does not match the number of commands");
        end
        $display("errors: %0d, checks: %0d of %0d", errors, checks, vecs.size());
        if (errors == 0 && checks == vecs.size()) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: alu_top.f
+incdir+include
rtl/alu_pkg.sv
rtl/alu_ctrl_fsm.sv
rtl/alu_iter_count.sv
rtl/alu_bit_count.sv
rtl/alu_iter_shift.sv
rtl/alu_arith_acc.sv
rtl/alu_top.sv
dv/alu_checker.sv
dv/alu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module alu_tb -f alu_top.f -o alu_sim \
    && ./obj_dir/alu_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
